// File: hw/branch_pkg.sv
`default_nettype none

package branch_pkg;

  // Machine word for PCs, operands and immediates
  typedef logic [31:0] word_t;

  // Fall-through distance to the next instruction
  localparam word_t INSTR_BYTES = 32'd4;

  // Conditional branch kinds coded like funct3 of the B-type encoding
  typedef enum logic [2:0] {
    BT_BEQ  = 3'b000,
    BT_BNE  = 3'b001,
    BT_BLT  = 3'b100,
    BT_BGE  = 3'b101,
    BT_BLTU = 3'b110,
    BT_BGEU = 3'b111
  } branch_type_t;

  // Zero means a conditional branch, other codes select a jump
  typedef enum logic [1:0] {
    JT_NONE = 2'd0,
    JT_JAL  = 2'd1,
    JT_JALR = 2'd2
  } jump_type_t;

  // Instruction under resolution with its sign-extended immediate
  typedef struct packed {
    word_t        current_pc;
    word_t        reg_a;
    word_t        reg_b;
    word_t        imm;
    branch_type_t branch_type;
    jump_type_t   j_type;
    logic         predicted_outcome;
  } branch_req_t;

  // Resolution result handed back to the core
  typedef struct packed {
    logic  resolved;
    logic  branch_outcome;
    logic  miss;
    word_t correct_pc;
    word_t branch_target;
    word_t jump_target;
    logic  update_btb;
  } branch_res_t;

  // One training write into the BTB
  typedef struct packed {
    logic  valid;
    word_t pc;
    word_t target;
    logic  taken;
  } btb_update_t;

  // Fetch-side prediction
  typedef struct packed {
    logic  hit;
    logic  taken;
    word_t target;
  } btb_pred_t;

endpackage

`default_nettype wire

// File: hw/fu_branch.sv
`timescale 1ns/1ps
`default_nettype none

module fu_branch (
  input  logic                    CLK,
  input  logic                    nRST,
  input  logic                    enable,
  input  branch_pkg::branch_req_t req,
  output branch_pkg::branch_res_t res,
  output branch_pkg::btb_update_t btb_upd
);

  logic operands_eq;
  logic less_signed;
  logic less_unsigned;
  logic cond_outcome;
  logic is_cond;
  logic same_branch;

  // Per-branch update state
  logic              btb_updated;
  branch_pkg::word_t last_branch_pc;

  branch_pkg::word_t seq_pc;
  branch_pkg::word_t pc_rel_target;
  branch_pkg::word_t jalr_sum;
  branch_pkg::word_t jalr_target;

  assign is_cond = (req.j_type == branch_pkg::JT_NONE);

  // Candidate next PCs
  assign seq_pc        = req.current_pc + branch_pkg::INSTR_BYTES;
  assign pc_rel_target = req.current_pc + req.imm;
  assign jalr_sum      = req.reg_a + req.imm;
  // JALR target always lands on an even address
  assign jalr_target   = {jalr_sum[31:1], 1'b0};

  always_comb begin
    operands_eq   = (req.reg_a == req.reg_b);
    less_signed   = ($signed(req.reg_a) < $signed(req.reg_b));
    less_unsigned = (req.reg_a < req.reg_b);
  end

  // Outcome by branch kind
  always_comb begin
    case (req.branch_type)
      branch_pkg::BT_BEQ:  cond_outcome = operands_eq;
      branch_pkg::BT_BNE:  cond_outcome = ~operands_eq;
      branch_pkg::BT_BLT:  cond_outcome = less_signed;
      branch_pkg::BT_BGE:  cond_outcome = ~less_signed;
      branch_pkg::BT_BLTU: cond_outcome = less_unsigned;
      branch_pkg::BT_BGEU: cond_outcome = ~less_unsigned;
      default:             cond_outcome = 1'b0;
    endcase
  end

  // Same branch still held by the issuer from the previous cycle
  assign same_branch = btb_updated && (last_branch_pc == req.current_pc);

  always_comb begin
    res            = '0;
    res.correct_pc = seq_pc;
    if (enable) begin
      res.resolved = 1'b1;
      case (req.j_type)
        branch_pkg::JT_NONE: begin
          res.branch_outcome = cond_outcome;
          res.branch_target  = pc_rel_target;
          res.correct_pc     = cond_outcome ? pc_rel_target : seq_pc;
          res.miss           = cond_outcome ^ req.predicted_outcome;
          // Only the first cycle of a held branch trains the BTB
          res.update_btb     = ~same_branch;
        end
        branch_pkg::JT_JAL: begin
          res.branch_outcome = 1'b1;
          res.jump_target    = pc_rel_target;
          res.correct_pc     = pc_rel_target;
        end
        branch_pkg::JT_JALR: begin
          res.branch_outcome = 1'b1;
          res.jump_target    = jalr_target;
          res.correct_pc     = jalr_target;
        end
        default: begin
          // Unused jump code resolves as fall-through
          res.correct_pc = seq_pc;
        end
      endcase
    end
  end

  // Training write to the BTB
  assign btb_upd.valid  = res.update_btb;
  assign btb_upd.pc     = req.current_pc;
  assign btb_upd.target = res.branch_target;
  assign btb_upd.taken  = res.branch_outcome;

  // Set while the previous cycle held an enabled conditional branch
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      btb_updated <= 1'b0;
    end else begin
      btb_updated <= enable && is_cond;
    end
  end

  // PC of the last enabled conditional branch
  always_ff @(posedge CLK) begin
    if (enable && is_cond) begin
      last_branch_pc <= req.current_pc;
    end
  end

endmodule

`default_nettype wire

// File: hw/btb.sv
`timescale 1ns/1ps
`default_nettype none

module btb #(
  parameter int BTB_ENTRIES = 16
) (
  input  logic                    CLK,
  input  logic                    nRST,
  input  branch_pkg::word_t       lookup_pc,
  output branch_pkg::btb_pred_t   pred,
  input  branch_pkg::btb_update_t upd
);

  localparam int IDX_W = $clog2(BTB_ENTRIES);
  // Bits 1:0 are always zero for aligned instructions
  localparam int TAG_W = 32 - IDX_W - 2;

  typedef struct packed {
    logic [TAG_W-1:0]  tag;
    branch_pkg::word_t target;
    logic [1:0]        ctr;
  } entry_t;

  logic [BTB_ENTRIES-1:0] valid;
  entry_t                 entries [BTB_ENTRIES];

  // Lookup side
  logic [IDX_W-1:0] rd_idx;
  logic [TAG_W-1:0] rd_tag;
  entry_t           rd_entry;
  logic             rd_hit;

  // Update side
  logic [IDX_W-1:0] wr_idx;
  logic [TAG_W-1:0] wr_tag;
  entry_t           old_entry;
  entry_t           wr_entry;
  logic             wr_hit;
  logic [1:0]       ctr_next;

  assign rd_idx   = lookup_pc[IDX_W+1:2];
  assign rd_tag   = lookup_pc[31:IDX_W+2];
  assign rd_entry = entries[rd_idx];
  assign rd_hit   = valid[rd_idx] && (rd_entry.tag == rd_tag);

  assign pred.hit    = rd_hit;
  // Counter at 2 or 3 predicts taken
  assign pred.taken  = rd_hit && rd_entry.ctr[1];
  assign pred.target = rd_hit ? rd_entry.target : '0;

  assign wr_idx    = upd.pc[IDX_W+1:2];
  assign wr_tag    = upd.pc[31:IDX_W+2];
  assign old_entry = entries[wr_idx];
  assign wr_hit    = valid[wr_idx] && (old_entry.tag == wr_tag);

  // Saturating 2-bit counter step
  always_comb begin
    if (!wr_hit) begin
      // Fresh allocation starts weakly toward the outcome
      ctr_next = upd.taken ? 2'd2 : 2'd1;
    end else if (upd.taken) begin
      ctr_next = (old_entry.ctr == 2'd3) ? 2'd3 : old_entry.ctr + 2'd1;
    end else begin
      ctr_next = (old_entry.ctr == 2'd0) ? 2'd0 : old_entry.ctr - 2'd1;
    end
  end

  always_comb begin
    wr_entry.tag    = wr_tag;
    wr_entry.target = upd.target;
    wr_entry.ctr    = ctr_next;
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      valid <= '0;
    end else if (upd.valid) begin
      valid[wr_idx] <= 1'b1;
    end
  end

  // Entry payload written on every update
  always_ff @(posedge CLK) begin
    if (upd.valid) begin
      entries[wr_idx] <= wr_entry;
    end
  end

endmodule

`default_nettype wire

// File: hw/branch_unit_top.sv
`timescale 1ns/1ps
`default_nettype none

module branch_unit_top #(
  parameter int BTB_ENTRIES = 16
) (
  input  logic                    CLK,
  input  logic                    nRST,

  // Fetch lookup
  input  branch_pkg::word_t       fetch_pc,
  output branch_pkg::btb_pred_t   prediction,

  // Issue and resolve
  input  logic                    enable,
  input  branch_pkg::branch_req_t req,
  output branch_pkg::branch_res_t res
);

  // Training path from the resolver into the BTB
  branch_pkg::btb_update_t btb_upd;

  fu_branch u_fu_branch (
    .CLK     (CLK),
    .nRST    (nRST),
    .enable  (enable),
    .req     (req),
    .res     (res),
    .btb_upd (btb_upd)
  );

  btb #(
    .BTB_ENTRIES (BTB_ENTRIES)
  ) u_btb (
    .CLK       (CLK),
    .nRST      (nRST),
    .lookup_pc (fetch_pc),
    .pred      (prediction),
    .upd       (btb_upd)
  );

endmodule

`default_nettype wire

// File: sim/branch_unit_assert.sv
`timescale 1ns/1ps
`default_nettype none

module branch_unit_assert (
  input logic                    CLK,
  input logic                    nRST,
  input logic                    enable,
  input branch_pkg::branch_req_t req,
  input branch_pkg::branch_res_t res
);

  logic is_jump;

  assign is_jump = (req.j_type != branch_pkg::JT_NONE);

  // The BTB only learns from conditional branches
  update_on_jump_a: assert property (@(posedge CLK) disable iff (!nRST)
    res.update_btb |-> !is_jump
  ) else $error("update_btb raised for a jump");

  // A held branch trains once
  update_twice_a: assert property (@(posedge CLK) disable iff (!nRST)
    (res.update_btb && $past(res.update_btb)) |-> (req.current_pc != $past(req.current_pc))
  ) else $error("update_btb raised twice in a row for one PC");

  resolved_a: assert property (@(posedge CLK) disable iff (!nRST)
    res.resolved == enable
  ) else $error("resolved differs from enable");

  miss_on_jump_a: assert property (@(posedge CLK) disable iff (!nRST)
    res.miss |-> !is_jump
  ) else $error("miss raised for a jump");

endmodule

bind fu_branch branch_unit_assert resolve_checks (
  .CLK    (CLK),
  .nRST   (nRST),
  .enable (enable),
  .req    (req),
  .res    (res)
);

`default_nettype wire

// File: sim/branch_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module branch_unit_tb;

  localparam int CLK_PERIOD   = 10;
  localparam int RESET_CYCLES = 10;
  localparam int NUM_REC      = 57;
  localparam int REC_WORDS    = 11;
  localparam int NUM_RAND     = 32;
  localparam int CYCLE_LIMIT  = NUM_REC + NUM_RAND + 200;

  logic                    CLK;
  logic                    nRST;
  branch_pkg::word_t       fetch_pc;
  branch_pkg::btb_pred_t   prediction;
  logic                    enable;
  branch_pkg::branch_req_t req;
  branch_pkg::branch_res_t res;

  // Flat record store with REC_WORDS words per pattern line
  logic [31:0] pat_mem [NUM_REC*REC_WORDS];
  logic [31:0] rng_state;
  int          cycle_count = 0;

  branch_unit_top #(
    .BTB_ENTRIES (16)
  ) dut_i (
    .CLK        (CLK),
    .nRST       (nRST),
    .fetch_pc   (fetch_pc),
    .prediction (prediction),
    .enable     (enable),
    .req        (req),
    .res        (res)
  );

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD/2) CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Testbench failed");
      $fatal(1, "Cycle limit reached");
    end
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Fail at %0t: %s expected %h, got %h", $time, name, expected, actual);
      $display("Testbench failed");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [2:0] pick_kind(input logic [31:0] r);
    case (r % 6)
      0:       pick_kind = branch_pkg::BT_BEQ;
      1:       pick_kind = branch_pkg::BT_BNE;
      2:       pick_kind = branch_pkg::BT_BLT;
      3:       pick_kind = branch_pkg::BT_BGE;
      4:       pick_kind = branch_pkg::BT_BLTU;
      default: pick_kind = branch_pkg::BT_BGEU;
    endcase
  endfunction

  // Reference compare from the branch rules
  function automatic logic compare_taken(input logic [2:0] kind, input logic [31:0] a,
                                         input logic [31:0] b);
    logic eq;
    logic ltu;
    logic lts;
    eq  = (a == b);
    ltu = (a < b);
    // With different signs the negative operand is the smaller one
    lts = (a[31] != b[31]) ? a[31] : ltu;
    case (kind)
      branch_pkg::BT_BEQ:  compare_taken = eq;
      branch_pkg::BT_BNE:  compare_taken = !eq;
      branch_pkg::BT_BLT:  compare_taken = lts;
      branch_pkg::BT_BGE:  compare_taken = !lts;
      branch_pkg::BT_BLTU: compare_taken = ltu;
      branch_pkg::BT_BGEU: compare_taken = !ltu;
      default:             compare_taken = 1'b0;
    endcase
  endfunction

  task automatic run_record(input int idx);
    int          base;
    logic [31:0] ctl;
    logic [31:0] flags;
    base  = idx * REC_WORDS;
    ctl   = pat_mem[base];
    flags = pat_mem[base + 6];
    if ($isunknown(ctl) || $isunknown(pat_mem[base + REC_WORDS - 1])) begin
      $display("Pattern file holds no complete record %0d", idx);
      $display("Testbench failed");
      $fatal(1, "Short pattern file");
    end
    enable                = ctl[12];
    req.j_type            = branch_pkg::jump_type_t'(ctl[9:8]);
    req.branch_type       = branch_pkg::branch_type_t'(ctl[6:4]);
    req.predicted_outcome = ctl[0];
    req.current_pc        = pat_mem[base + 1];
    req.reg_a             = pat_mem[base + 2];
    req.reg_b             = pat_mem[base + 3];
    req.imm               = pat_mem[base + 4];
    fetch_pc              = pat_mem[base + 5];
    #(CLK_PERIOD/2 - 1);
    check_value("res.resolved", 32'(res.resolved), 32'(flags[20]));
    check_value("res.branch_outcome", 32'(res.branch_outcome), 32'(flags[16]));
    check_value("res.miss", 32'(res.miss), 32'(flags[12]));
    check_value("res.update_btb", 32'(res.update_btb), 32'(flags[8]));
    check_value("prediction.hit", 32'(prediction.hit), 32'(flags[4]));
    check_value("prediction.taken", 32'(prediction.taken), 32'(flags[0]));
    check_value("res.correct_pc", res.correct_pc, pat_mem[base + 7]);
    check_value("res.branch_target", res.branch_target, pat_mem[base + 8]);
    check_value("res.jump_target", res.jump_target, pat_mem[base + 9]);
    check_value("prediction.target", prediction.target, pat_mem[base + 10]);
    @(negedge CLK);
  endtask

  task automatic run_random_case(input int n);
    branch_pkg::word_t a;
    branch_pkg::word_t b;
    branch_pkg::word_t imm;
    branch_pkg::word_t pc;
    branch_pkg::word_t target;
    logic [2:0]        kind;
    logic              pred;
    logic              taken;
    rng_state = xorshift(rng_state);
    a = rng_state;
    rng_state = xorshift(rng_state);
    // Equal operands in about a quarter of the cases
    b = (rng_state[1:0] == 2'b00) ? a : rng_state;
    rng_state = xorshift(rng_state);
    kind = pick_kind(rng_state);
    pred = rng_state[31];
    imm  = {{19{rng_state[20]}}, rng_state[20:9], 1'b0};
    pc   = 32'h0000_8000 + 32'(n) * 32'd4;
    enable                = 1'b1;
    req.j_type            = branch_pkg::JT_NONE;
    req.branch_type       = branch_pkg::branch_type_t'(kind);
    req.predicted_outcome = pred;
    req.current_pc        = pc;
    req.reg_a             = a;
    req.reg_b             = b;
    req.imm               = imm;
    fetch_pc              = pc;
    taken  = compare_taken(kind, a, b);
    target = pc + imm;
    #(CLK_PERIOD/2 - 1);
    check_value("res.resolved", 32'(res.resolved), 32'd1);
    check_value("res.branch_outcome", 32'(res.branch_outcome), 32'(taken));
    check_value("res.miss", 32'(res.miss), 32'(taken ^ pred));
    check_value("res.update_btb", 32'(res.update_btb), 32'd1);
    check_value("res.correct_pc", res.correct_pc, taken ? target : pc + 32'd4);
    check_value("res.branch_target", res.branch_target, target);
    check_value("res.jump_target", res.jump_target, 32'd0);
    @(negedge CLK);
  endtask

  initial begin
    nRST      = 1'b0;
    enable    = 1'b0;
    req       = '0;
    fetch_pc  = '0;
    rng_state = 32'd17269;
    $readmemh("sim/branch_patterns.hex", pat_mem);
    repeat (RESET_CYCLES) @(posedge CLK);
    @(negedge CLK);
    nRST = 1'b1;
    for (int i = 0; i < NUM_REC; i++) begin
      run_record(i);
    end
    // Extra compare cases on fresh PCs
    for (int i = 0; i < NUM_RAND; i++) begin
      run_random_case(i);
    end
    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim/branch_patterns.hex
// ctl nibbles: enable j_type branch_type predicted | pc reg_a reg_b imm fetch_pc
// exp nibbles: resolved outcome miss update_btb hit taken | correct_pc branch_target jump_target pred_target
0000 00001000 00000000 00000000 00000000 0000F000 000000 00001004 00000000 00000000 00000000
1000 00001004 12345678 12345678 00000100 0000F000 111100 00001104 00001104 00000000 00000000
1000 00001008 12345678 12345679 00000100 0000F000 100100 0000100C 00001108 00000000 00000000
1011 0000100C FFFFFFFF FFFFFFFF 00000100 0000F000 101100 00001010 0000110C 00000000 00000000
1011 00001010 00000000 00000001 00000100 0000F000 110100 00001110 00001110 00000000 00000000
1041 00001014 FFFFFFFF 00000001 00000100 0000F000 110100 00001114 00001114 00000000 00000000
1040 00001018 7FFFFFFF 80000000 00000100 0000F000 100100 0000101C 00001118 00000000 00000000
1041 0000101C 80000000 80000000 00000100 0000F000 101100 00001020 0000111C 00000000 00000000
1051 00001020 80000000 7FFFFFFF 00000100 0000F000 101100 00001024 00001120 00000000 00000000
1050 00001024 00000005 00000005 00000100 0000F000 111100 00001124 00001124 00000000 00000000
1051 00001028 00000000 FFFFFFFF 00000100 0000F000 110100 00001128 00001128 00000000 00000000
1060 0000102C 00000001 FFFFFFFF 00000100 0000F000 111100 0000112C 0000112C 00000000 00000000
1060 00001030 FFFFFFFF 00000001 00000100 0000F000 100100 00001034 00001130 00000000 00000000
1061 00001034 80000000 80000000 00000100 0000F000 101100 00001038 00001134 00000000 00000000
1071 00001038 80000000 7FFFFFFF 00000100 0000F000 110100 00001138 00001138 00000000 00000000
1071 0000103C 00000000 00000001 00000100 0000F000 101100 00001040 0000113C 00000000 00000000
1070 00001040 00000000 00000000 00000100 0000F000 111100 00001140 00001140 00000000 00000000
1001 00001044 00000000 00000000 FFFFFF00 0000F000 110100 00000F44 00000F44 00000000 00000000
1010 00001048 ABCD0000 ABCD0000 FFFFFFF0 0000F000 100100 0000104C 00001038 00000000 00000000
1040 0000104C FFFFFFFE FFFFFFFF 00000100 0000F000 111100 0000114C 0000114C 00000000 00000000
1070 00001050 FFFFFFFF FFFFFFFE 00000100 0000F000 111100 00001150 00001150 00000000 00000000
1061 00001054 7FFFFFFF 80000000 00000100 0000F000 110100 00001154 00001154 00000000 00000000
1050 00001058 7FFFFFFF 80000000 00000100 0000F000 111100 00001158 00001158 00000000 00000000
1100 00002000 00000000 00000000 00000800 0000F000 110000 00002800 00000000 00002800 00000000
1101 00002004 00000000 00000000 FFFFF000 0000F000 110000 00001004 00000000 00001004 00000000
1200 00002008 00003001 00000000 00000000 0000F000 110000 00003000 00000000 00003000 00000000
1201 0000200C 00004000 00000000 00000011 0000F000 110000 00004010 00000000 00004010 00000000
1200 00002010 00005000 00000000 FFFFFFFF 0000F000 110000 00004FFE 00000000 00004FFE 00000000
1200 00002014 00000000 00000000 00000004 0000F000 110000 00000004 00000000 00000004 00000000
0000 00002018 00000000 00000000 00000000 0000F000 000000 0000201C 00000000 00000000 00000000
0000 00003000 00000000 00000000 00000000 00003000 000000 00003004 00000000 00000000 00000000
1000 00003000 00000001 00000001 00000040 00003000 111100 00003040 00003040 00000000 00000000
0000 00003100 00000000 00000000 00000000 00003000 000011 00003104 00000000 00000000 00003040
1001 00003000 00000001 00000002 00000040 00003000 101111 00003004 00003040 00000000 00003040
0000 00003100 00000000 00000000 00000000 00003000 000010 00003104 00000000 00000000 00003040
1010 00003000 00000007 00000007 00000040 00003000 100110 00003004 00003040 00000000 00003040
0000 00003100 00000000 00000000 00000000 00003000 000010 00003104 00000000 00000000 00003040
1000 00003000 00000000 00000000 00000080 00003000 111110 00003080 00003080 00000000 00003040
0000 00003100 00000000 00000000 00000000 00003000 000010 00003104 00000000 00000000 00003080
1001 00003000 00000000 00000000 00000080 00003000 110110 00003080 00003080 00000000 00003080
0000 00003100 00000000 00000000 00000000 00003000 000011 00003104 00000000 00000000 00003080
1011 00003040 00000000 00000001 00000010 00003000 110111 00003050 00003050 00000000 00003080
0000 00003100 00000000 00000000 00000000 00003000 000000 00003104 00000000 00000000 00000000
0000 00003100 00000000 00000000 00000000 00003040 000011 00003104 00000000 00000000 00003050
1041 00004008 FFFFFFF0 00000010 00000020 00004008 110100 00004028 00004028 00000000 00000000
1041 00004008 FFFFFFF0 00000010 00000020 00004008 110011 00004028 00004028 00000000 00004028
1041 00004008 FFFFFFF0 00000010 00000020 00004008 110011 00004028 00004028 00000000 00004028
1040 0000400C 00000010 FFFFFFF0 00000020 00004008 100111 00004010 0000402C 00000000 00004028
1040 0000400C 00000010 FFFFFFF0 00000020 00004008 100011 00004010 0000402C 00000000 00004028
1041 00004008 FFFFFFF0 00000010 00000020 00004008 110111 00004028 00004028 00000000 00004028
0000 00004100 00000000 00000000 00000000 00004008 000011 00004104 00000000 00000000 00004028
1041 00004008 00000010 FFFFFFF0 00000020 00004008 101111 0000400C 00004028 00000000 00004028
1100 00004008 00000000 00000000 00000100 00004008 110011 00004108 00000000 00004108 00004028
1040 00004008 00000010 FFFFFFF0 00000020 00004008 100111 0000400C 00004028 00000000 00004028
0000 00004100 00000000 00000000 00000000 00004008 000010 00004104 00000000 00000000 00004028
0000 00004100 00000000 00000000 00000000 0000400C 000010 00004104 00000000 00000000 0000402C
0000 00004100 00000000 00000000 00000000 0000F000 000000 00004104 00000000 00000000 00000000

// File: compile.f
hw/branch_pkg.sv
hw/fu_branch.sv
hw/btb.sv
hw/branch_unit_top.sv
sim/branch_unit_assert.sv
sim/branch_unit_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the branch unit testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert --top-module branch_unit_tb \
  -f compile.f --Mdir obj_dir -o branch_unit_sim

# A $fatal in the run gives a failing exit status
./obj_dir/branch_unit_sim
